// ==== filelist.f ====
verilog/posit_format_pkg.sv
verilog/posit_raw_pkg.sv
verilog/leading_one_detect.sv
verilog/posit_decode.sv
verilog/posit_add_raw.sv
verilog/posit_encode.sv
verilog/posit_adder_top.sv
sim/clock_gen.sv
sim/tb_posit_adder.sv

// ==== Makefile ====
TOP = tb_posit_adder

sim:
	verilator --binary --timing --assert --Wno-fatal -Mdir obj_dir -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== sim/tb_posit_adder.sv ====
// ====================================================================
// Self-checking testbench for the posit adder, table then random pairs
// ====================================================================

`timescale 1ns/100ps

module tb_posit_adder
    import posit_format_pkg::*;
();

    localparam int n_rows  = 14;
    localparam int n_pairs = 24;
    // Driven on a falling edge, done is seen six falling edges later
    localparam int done_delay_ns = 60;
    localparam int watchdog_ns   = 100 + (n_rows + 3 * n_pairs + 20) * 10;

    // Check kinds for queued operations
    localparam logic [1:0] chk_exact = 2'd0;
    localparam logic [1:0] chk_ref   = 2'd1;
    localparam logic [1:0] chk_swap  = 2'd2;
    localparam logic [1:0] chk_neg   = 2'd3;

    // Columns: idle cycle after row, operand a, operand b, expected sum, expected inexact
    localparam logic [97:0] vectors [n_rows] = '{
        {1'b0, 32'h40000000, 32'h40000000, 32'h48000000, 1'b0},
        {1'b0, 32'h40000000, 32'h38000000, 32'h44000000, 1'b0},
        {1'b1, 32'h40000000, 32'hC0000000, 32'h00000000, 1'b0},
        {1'b0, 32'h48000000, 32'hC8000000, 32'h44000000, 1'b0},
        {1'b0, 32'h44000000, 32'h80000000, 32'h80000000, 1'b0},
        {1'b0, 32'h80000000, 32'hC0000000, 32'h80000000, 1'b0},
        {1'b1, 32'h80000000, 32'h80000000, 32'h80000000, 1'b0},
        {1'b0, 32'h00000000, 32'h44000000, 32'h44000000, 1'b0},
        {1'b0, 32'hB8000000, 32'h00000000, 32'hB8000000, 1'b0},
        {1'b1, 32'h00000000, 32'h00000000, 32'h00000000, 1'b0},
        // maxpos twice saturates, minpos and one ulp against 1.0
        {1'b0, 32'h7FFFFFFF, 32'h7FFFFFFF, 32'h7FFFFFFF, 1'b1},
        {1'b0, 32'h40000000, 32'h00000001, 32'h40000000, 1'b1},
        {1'b0, 32'h40000000, 32'h00A00000, 32'h40000001, 1'b0},
        {1'b0, 32'hC0000000, 32'hC0000000, 32'hB8000000, 1'b0}
    };

    typedef struct packed {
        logic [posit_width-1:0] expected;
        logic                   exp_inexact;
        logic [1:0]             kind;
        logic [63:0]            issued;
    } pending_t;

    logic                   clk;
    logic                   arst_n;
    logic                   start;
    logic [posit_width-1:0] in_a;
    logic [posit_width-1:0] in_b;
    logic [posit_width-1:0] result;
    logic                   done;
    logic                   inexact;

    pending_t               pending [$];
    pending_t               head;
    logic [posit_width-1:0] ref_result;
    logic                   ref_inexact;
    int                     mismatches;
    int                     protocol_errors;
    int                     seed;

    clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    posit_adder_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .in_a    (in_a),
        .in_b    (in_b),
        .result  (result),
        .done    (done),
        .inexact (inexact)
    );

    // One operation per call, queued with what its result must satisfy
    task automatic issue_op(input logic [posit_width-1:0] a, input logic [posit_width-1:0] b,
                            input logic [1:0] kind, input logic [posit_width-1:0] expected,
                            input logic exp_inexact);
        pending_t p;
        p.expected    = expected;
        p.exp_inexact = exp_inexact;
        p.kind        = kind;
        p.issued      = $time;
        pending.push_back(p);
        start = 1'b1;
        in_a  = a;
        in_b  = b;
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        start = 1'b0;
        @(negedge clk);
    endtask

    task automatic pick_operand(output logic [posit_width-1:0] w);
        do
            w = $random(seed);
        while (w == posit_nar);
    endtask

    task automatic check_result(input pending_t p);
        logic [posit_width-1:0] want;
        logic                   want_inx;
        want     = p.expected;
        want_inx = p.exp_inexact;
        if (p.kind == chk_swap)
        begin
            want     = ref_result;
            want_inx = ref_inexact;
        end
        else if (p.kind == chk_neg)
        begin
            want     = -ref_result;
            want_inx = ref_inexact;
        end
        if (p.kind == chk_ref)
        begin
            ref_result  = result;
            ref_inexact = inexact;
        end
        else
        begin
            if (result !== want)
            begin
                $display("mismatch at %0t: result expected %h actual %h", $time, want, result);
                mismatches++;
            end
            if (inexact !== want_inx)
            begin
                $display("mismatch at %0t: inexact expected %b actual %b",
                         $time, want_inx, inexact);
                mismatches++;
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d protocol errors", mismatches, protocol_errors);
    endtask

    // Output monitor, outputs settle after the rising edge
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            if (done !== 1'b0)
            begin
                $display("error at %0t: done was not low during reset", $time);
                protocol_errors++;
            end
        end
        else if (done === 1'b1)
        begin
            if (pending.size() == 0)
            begin
                $display("error at %0t: done pulse with no operation pending", $time);
                protocol_errors++;
            end
            else
            begin
                head = pending.pop_front();
                if ($time - head.issued != done_delay_ns)
                begin
                    $display("error at %0t: done for the start at %0t came at the wrong cycle",
                             $time, head.issued);
                    protocol_errors++;
                end
                check_result(head);
            end
        end
        else if (pending.size() != 0 && $time >= pending[0].issued + done_delay_ns)
        begin
            head = pending.pop_front();
            $display("error at %0t: no done for the start at %0t", $time, head.issued);
            protocol_errors++;
        end
    end

    initial
    begin
        logic [posit_width-1:0] a;
        logic [posit_width-1:0] b;
        start           = 1'b0;
        in_a            = '0;
        in_b            = '0;
        mismatches      = 0;
        protocol_errors = 0;
        seed            = 32'hb62;
        @(posedge arst_n);
        @(negedge clk);

        for (int i = 0; i < n_rows; i++)
        begin
            issue_op(vectors[i][96:65], vectors[i][64:33], chk_exact,
                     vectors[i][32:1], vectors[i][0]);
            if (vectors[i][97])
                idle_cycle();
        end

        // Symmetry checks, a+b is the reference for b+a and for -a + -b
        for (int i = 0; i < n_pairs; i++)
        begin
            pick_operand(a);
            pick_operand(b);
            issue_op(a, b, chk_ref, '0, 1'b0);
            issue_op(b, a, chk_swap, '0, 1'b0);
            issue_op(-a, -b, chk_neg, '0, 1'b0);
        end
        start = 1'b0;

        while (pending.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);

        report_counts();
        if (mismatches == 0 && protocol_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: %0d operations still waiting for done", pending.size());
        report_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sim/clock_gen.sv ====
// ====================================================================
// Testbench clock and reset, 10 ns period, reset held for 10 cycles
// ====================================================================

`timescale 1ns/100ps

module clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 10
)
(
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial
    begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// ==== verilog/posit_adder_top.sv ====
// ====================================================================
// Posit adder top, decoder then raw adder then encoder, six cycles
// ====================================================================

`timescale 1ns/100ps

module posit_adder_top
    import posit_format_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic [posit_width-1:0] in_a,
    input  logic [posit_width-1:0] in_b,
    output logic [posit_width-1:0] result,
    output logic                   done,
    output logic                   inexact
);

    logic [raw_width-1:0]     raw_a;
    logic [raw_width-1:0]     raw_b;
    logic                     raw_start;
    logic [raw_sum_width-1:0] sum_raw;
    logic                     sum_done;
    logic                     sum_truncated;

    posit_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .in_a      (in_a),
        .in_b      (in_b),
        .raw_a     (raw_a),
        .raw_b     (raw_b),
        .raw_start (raw_start)
    );

    posit_add_raw u_add (
        .clk           (clk),
        .arst_n        (arst_n),
        .raw_start     (raw_start),
        .raw_a         (raw_a),
        .raw_b         (raw_b),
        .sum_raw       (sum_raw),
        .sum_done      (sum_done),
        .sum_truncated (sum_truncated)
    );

    posit_encode u_encode (
        .clk           (clk),
        .arst_n        (arst_n),
        .sum_done      (sum_done),
        .sum_truncated (sum_truncated),
        .sum_raw       (sum_raw),
        .result        (result),
        .done          (done),
        .inexact       (inexact)
    );

endmodule

// ==== verilog/posit_encode.sv ====
// ====================================================================
// Posit encoder, rounds a raw sum to nearest-even and packs the word
// ====================================================================

`timescale 1ns/100ps

module posit_encode
    import posit_format_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     sum_done,
    input  logic                     sum_truncated,
    input  logic [raw_sum_width-1:0] sum_raw,
    output logic [posit_width-1:0]   result,
    output logic                     done,
    output logic                     inexact
);

    // Room for the longest regime run plus exponent and fraction
    localparam int body_width = 2 * posit_width;

    raw_sum_word_u                 sum_w;
    logic signed [scale_width-1:0] enc_k;
    logic [posit_es-1:0]           enc_e;
    logic                          enc_fill;
    logic [5:0]                    enc_run;
    logic [body_width-1:0]         enc_body;
    logic [2*body_width-1:0]       enc_shifted;
    logic [posit_width-2:0]        enc_mag;
    logic                          enc_guard;
    logic                          enc_sticky;
    logic                          enc_round_up;
    logic [posit_width-2:0]        enc_rounded;
    logic [posit_width-2:0]        enc_final_mag;
    logic [posit_width-1:0]        enc_word;
    logic                          enc_inexact;

    assign sum_w.bits = sum_raw;

    // Regime k and exponent e from scale = 4k + e
    assign enc_k    = sum_w.f.scale >>> posit_es;
    assign enc_e    = sum_w.f.scale[posit_es-1:0];
    assign enc_fill = ~enc_k[scale_width-1];
    assign enc_run  = enc_fill ? 6'(enc_k + 8'sd1) : 6'(-enc_k);

    // Terminating bit, exponent and fraction, then the run slides in on top
    assign enc_body    = {~enc_fill, enc_e, sum_w.f.fraction,
                          {(body_width-abits-posit_es-1){1'b0}}};
    assign enc_shifted = {{body_width{enc_fill}}, enc_body} >> enc_run;

    assign enc_mag      = enc_shifted[body_width-1 -: posit_width-1];
    assign enc_guard    = enc_shifted[body_width-posit_width];
    assign enc_sticky   = |enc_shifted[body_width-posit_width-1:0] | sum_truncated;
    assign enc_round_up = enc_guard & (enc_sticky | enc_mag[0]);
    assign enc_rounded  = enc_mag + (posit_width-1)'(enc_round_up);

    always_comb
    begin
        enc_final_mag = enc_rounded;
        enc_inexact   = enc_guard | enc_sticky;
        // Out of range saturates to maxpos or minpos, never to zero or NaR
        if (sum_w.f.scale > max_scale)
        begin
            enc_final_mag = '1;
            enc_inexact   = 1'b1;
        end
        else if (sum_w.f.scale < min_scale)
        begin
            enc_final_mag = (posit_width-1)'(1);
            enc_inexact   = 1'b1;
        end
        enc_word = sum_w.f.sgn ? -{1'b0, enc_final_mag} : {1'b0, enc_final_mag};
        if (sum_w.f.inf)
        begin
            enc_word    = posit_nar;
            enc_inexact = 1'b0;
        end
        else if (sum_w.f.zero)
        begin
            enc_word    = posit_zero;
            enc_inexact = sum_truncated;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            done <= 1'b0;
        else
            done <= sum_done;
    end

    always_ff @(posedge clk)
    begin
        result  <= enc_word;
        inexact <= enc_inexact;
    end

    // Rounding of a finite nonzero sum never lands on zero or NaR
    a_finite_stays_finite: assert property (@(posedge clk) disable iff (!arst_n)
        sum_done && !sum_w.f.inf && !sum_w.f.zero |->
            (enc_word != posit_zero) && (enc_word != posit_nar))
        else $error("finite sum encoded as zero or NaR");

endmodule

// ==== verilog/posit_add_raw.sv ====
// ====================================================================
// Four-stage raw adder: order, align with sticky, add, normalize
// ====================================================================

`timescale 1ns/100ps

module posit_add_raw
    import posit_format_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     raw_start,
    input  logic [raw_width-1:0]     raw_a,
    input  logic [raw_width-1:0]     raw_b,
    output logic [raw_sum_width-1:0] sum_raw,
    output logic                     sum_done,
    output logic                     sum_truncated
);

    localparam int guard_bits = abits - frac_width - 1;

    function automatic raw_fields_t clean_zero(input raw_fields_t v);
        raw_fields_t c;
        c = v;
        if (v.zero)
        begin
            c      = '0;
            c.zero = 1'b1;
        end
        return c;
    endfunction

    logic r0_start;
    logic r1_start;
    logic r2_start;
    logic r3_start;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r0_start <= 1'b0;
            r1_start <= 1'b0;
            r2_start <= 1'b0;
            r3_start <= 1'b0;
        end
        else
        begin
            r0_start <= raw_start;
            r1_start <= r0_start;
            r2_start <= r1_start;
            r3_start <= r2_start;
        end
    end

    // Stage r0, operand registers and magnitude ordering
    raw_word_u   in_a_w;
    raw_word_u   in_b_w;
    raw_fields_t r0_a;
    raw_fields_t r0_b;
    raw_fields_t r0_hi;
    raw_fields_t r0_lo;
    logic        r0_a_ge_b;
    logic        r0_add;
    logic [7:0]  r0_diff;

    assign in_a_w.bits = raw_a;
    assign in_b_w.bits = raw_b;

    always_ff @(posedge clk)
    begin
        r0_a <= clean_zero(in_a_w.f);
        r0_b <= clean_zero(in_b_w.f);
    end

    // A zero operand never wins, whatever its cleared scale says
    assign r0_a_ge_b = r0_b.zero | (~r0_a.zero & ((r0_a.scale > r0_b.scale) |
                       ((r0_a.scale == r0_b.scale) & (r0_a.fraction >= r0_b.fraction))));
    assign r0_hi     = r0_a_ge_b ? r0_a : r0_b;
    assign r0_lo     = r0_a_ge_b ? r0_b : r0_a;
    assign r0_add    = ~(r0_a.sgn ^ r0_b.sgn);
    // At most 240, fits unsigned
    assign r0_diff   = 8'(r0_hi.scale - r0_lo.scale);

    // Stage r1, alignment and add or subtract
    raw_fields_t        r1_hi;
    raw_fields_t        r1_lo;
    logic               r1_add;
    logic [7:0]         r1_diff;
    logic [abits-1:0]   r1_hi_sig;
    logic [abits-1:0]   r1_lo_sig;
    logic [2*abits-1:0] r1_lo_wide;
    logic               r1_trunc;
    logic [abits:0]     r1_mag;

    always_ff @(posedge clk)
    begin
        r1_hi   <= r0_hi;
        r1_lo   <= r0_lo;
        r1_add  <= r0_add;
        r1_diff <= r0_diff;
    end

    assign r1_hi_sig  = {~r1_hi.zero, r1_hi.fraction, {guard_bits{1'b0}}};
    assign r1_lo_sig  = {~r1_lo.zero, r1_lo.fraction, {guard_bits{1'b0}}};
    assign r1_lo_wide = {r1_lo_sig, {abits{1'b0}}} >> r1_diff;
    // Beyond the window the whole smaller operand is lost
    assign r1_trunc   = (r1_diff >= abits) ? ~r1_lo.zero : |r1_lo_wide[abits-1:0];
    assign r1_mag     = r1_add ? {1'b0, r1_hi_sig} + {1'b0, r1_lo_wide[2*abits-1:abits]}
                               : {1'b0, r1_hi_sig} - {1'b0, r1_lo_wide[2*abits-1:abits]};

    // Stage r2, normalization
    raw_fields_t                   r2_hi;
    raw_fields_t                   r2_lo;
    logic [abits:0]                r2_mag;
    logic                          r2_trunc;
    logic [4:0]                    r2_lead_pos;
    logic signed [scale_width+1:0] r2_scale_wide;
    logic [abits:0]                r2_norm;
    raw_sum_fields_t               r2_sum;

    always_ff @(posedge clk)
    begin
        r2_hi    <= r1_hi;
        r2_lo    <= r1_lo;
        r2_mag   <= r1_mag;
        r2_trunc <= r1_trunc;
    end

    leading_one_detect #(
        .lod_width (abits + 1)
    ) u_lod (
        .in_bits  (r2_mag),
        .lead_pos (r2_lead_pos)
    );

    // Hidden bit sits one below the carry, so lead_pos of 1 keeps the scale
    assign r2_scale_wide = $signed(r2_hi.scale) + 10'sd1 - $signed({1'b0, r2_lead_pos});
    assign r2_norm       = r2_mag << (r2_lead_pos + 6'd1);

    always_comb
    begin
        r2_sum.sgn      = r2_hi.sgn;
        // Only deep cancellation can leave the 8-bit range, and only downward
        if (r2_scale_wide < -(2 ** (scale_width - 1)))
            r2_sum.scale = {1'b1, {(scale_width-1){1'b0}}};
        else
            r2_sum.scale = r2_scale_wide[scale_width-1:0];
        r2_sum.fraction = r2_norm[abits:1];
        r2_sum.inf      = r2_hi.inf | r2_lo.inf;
        r2_sum.zero     = (r2_hi.zero & r2_lo.zero) | ~|r2_mag;
    end

    // Stage r3, output register
    raw_sum_fields_t r3_sum;
    logic            r3_trunc;
    raw_sum_word_u   sum_w;

    always_ff @(posedge clk)
    begin
        r3_sum   <= r2_sum;
        r3_trunc <= r2_trunc;
    end

    always_comb
    begin
        sum_w.f      = r3_sum;
        sum_w.f.zero = r3_sum.zero & ~r3_sum.inf;
    end

    assign sum_raw       = sum_w.bits;
    assign sum_done      = r3_start;
    assign sum_truncated = r3_trunc;

    // Exact cancellation cannot happen once bits of the smaller operand were lost
    a_zero_exact: assert property (@(posedge clk) disable iff (!arst_n)
        sum_done && sum_w.f.zero |-> !sum_truncated)
        else $error("zero sum flagged as truncated");

endmodule

// ==== verilog/posit_decode.sv ====
// ====================================================================
// Posit decoder, turns two posit words into serialized raw operands
// ====================================================================

`timescale 1ns/100ps

module posit_decode
    import posit_format_pkg::*;
    import posit_raw_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic [posit_width-1:0] in_a,
    input  logic [posit_width-1:0] in_b,
    output logic [raw_width-1:0]   raw_a,
    output logic [raw_width-1:0]   raw_b,
    output logic                   raw_start
);

    function automatic logic [raw_width-1:0] decode_word(input logic [posit_width-1:0] word);
        logic                          sgn;
        logic [posit_width-1:0]        mag;
        logic [posit_width-2:0]        body;
        logic [posit_width-2:0]        rest;
        logic [5:0]                    run;
        logic                          stop;
        logic signed [scale_width-1:0] run_s;
        logic signed [scale_width-1:0] regime;
        logic signed [scale_width-1:0] scale;
        sgn  = word[posit_width-1];
        mag  = sgn ? -word : word;
        body = mag[posit_width-2:0];
        run  = '0;
        stop = 1'b0;
        // Length of the run of identical bits below the sign
        for (int i = posit_width - 2; i >= 0; i--)
        begin
            if (!stop && body[i] == body[posit_width-2])
                run = run + 6'd1;
            else
                stop = 1'b1;
        end
        run_s  = scale_width'(run);
        regime = body[posit_width-2] ? run_s - 1 : -run_s;
        // Drop the run and its terminating bit, exponent and fraction follow
        rest   = body << (run + 6'd1);
        scale  = (regime <<< posit_es) + rest[posit_width-2 -: posit_es];
        if (word == posit_zero)
            return {{(raw_width-1){1'b0}}, 1'b1};
        if (word == posit_nar)
            return {{(raw_width-2){1'b0}}, 2'b10};
        return {sgn, scale, rest[posit_width-2-posit_es -: frac_width], 2'b00};
    endfunction

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            raw_start <= 1'b0;
        else
            raw_start <= start;
    end

    always_ff @(posedge clk)
    begin
        raw_a <= decode_word(in_a);
        raw_b <= decode_word(in_b);
    end

    raw_word_u chk_a;
    raw_word_u chk_b;
    assign chk_a.bits = raw_a;
    assign chk_b.bits = raw_b;

    // Every decodable word lands inside the scale range the encoder handles
    a_scale_range: assert property (@(posedge clk) disable iff (!arst_n)
        raw_start |-> (chk_a.f.scale >= min_scale) && (chk_a.f.scale <= max_scale) &&
                      (chk_b.f.scale >= min_scale) && (chk_b.f.scale <= max_scale))
        else $error("decoded scale outside posit range");

endmodule

// ==== verilog/leading_one_detect.sv ====
// ====================================================================
// Leading-one detector, counts the zeros above the highest set bit
// ====================================================================

`timescale 1ns/100ps

module leading_one_detect #(
    parameter int lod_width = 31
)
(
    input  logic [lod_width-1:0] in_bits,
    output logic [4:0]           lead_pos
);

    // Scan upward so the highest set bit is the one that sticks
    always_comb
    begin
        lead_pos = 5'(lod_width - 1);
        for (int i = 0; i < lod_width; i++)
        begin
            if (in_bits[i])
                lead_pos = 5'(lod_width - 1 - i);
        end
    end

endmodule

// ==== verilog/posit_raw_pkg.sv ====
// ====================================================================
// Raw operand and raw sum layouts shared by decoder, adder and encoder
// ====================================================================

package posit_raw_pkg;

    import posit_format_pkg::*;

    // Two's-complement scale, regime times four plus exponent
    localparam int scale_width = 8;

    // Serialized raw operand: sign, scale, fraction, inf, zero
    localparam int raw_width = 1 + scale_width + frac_width + 2;

    // Adder working fraction with room for the guard bits
    localparam int abits = frac_width + 3;

    // Serialized raw sum, fraction is abits wide below the hidden bit
    localparam int raw_sum_width = 1 + scale_width + abits + 2;

    typedef struct packed {
        logic                          sgn;
        logic signed [scale_width-1:0] scale;
        logic [frac_width-1:0]         fraction;
        logic                          inf;
        logic                          zero;
    } raw_fields_t;

    typedef struct packed {
        logic                          sgn;
        logic signed [scale_width-1:0] scale;
        logic [abits-1:0]              fraction;
        logic                          inf;
        logic                          zero;
    } raw_sum_fields_t;

    // Same word seen as plain bits or as fields
    typedef union packed {
        logic [raw_width-1:0] bits;
        raw_fields_t          f;
    } raw_word_u;

    typedef union packed {
        logic [raw_sum_width-1:0] bits;
        raw_sum_fields_t          f;
    } raw_sum_word_u;

endpackage

// ==== verilog/posit_format_pkg.sv ====
// ====================================================================
// Posit format constants for 32-bit posits with two exponent bits
// ====================================================================

package posit_format_pkg;

    // Word layout
    localparam int posit_width = 32;
    localparam int posit_es    = 2;

    // Fraction bits kept in the raw operand, without the hidden bit
    localparam int frac_width = 27;

    // Largest and smallest scale, useed is 16 and the regime runs up to 30
    localparam int max_scale = 120;
    localparam int min_scale = -120;

    // Special patterns
    localparam logic [posit_width-1:0] posit_nar  = {1'b1, {(posit_width-1){1'b0}}};
    localparam logic [posit_width-1:0] posit_zero = '0;

endpackage
